// ==== design/fetch_macros.svh ====
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// shared sizing for the fetch front end

// data path and pc width
`define XLEN 32

// instruction memory depth as log2 of the word count
// 8 gives 256 words, i.e. 1 KiB of program space
`define IMEM_AW 8

// first-stage pc right after reset
`define RESET_PC 32'h74

`endif

// ==== design/fetchPkg.sv ====
`default_nettype none

`include "fetch_macros.svh"

package fetchPkg;

	// next-pc source chosen by the core
	typedef enum logic [1:0]
	{
		pcSeq    = 2'd0, // pc + 4
		pcZero   = 2'd1, // restart at address 0
		pcTarget = 2'd2, // branch or jump target
		pcHold   = 2'd3  // keep the first-stage pc
	} pcSelT;

	// control from the core into the fetch stage
	typedef struct packed
	{
		logic stall;               // freeze both pc stages
		logic replay;              // step the output back one word
		pcSelT pcSel;
		logic [`XLEN-1:0] target;  // only looked at for pcTarget
	} fetchCtrl;

	// fetched word handed to decode
	// pc and instr always belong to the same word
	typedef struct packed
	{
		logic valid;
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] instr;
	} fetchPacket;

endpackage

`default_nettype wire

// ==== design/busPkg.sv ====
`default_nettype none

`include "fetch_macros.svh"

package busPkg;

	// Wishbone classic master to slave
	typedef struct packed
	{
		logic cyc;
		logic stb;
		logic we;                // 1 for write
		logic [`XLEN-1:0] adr;   // byte address
		logic [`XLEN-1:0] dat;   // write data
		logic [3:0] sel;         // byte lanes, bit 0 is dat[7:0]
	} wbReq;

	// Wishbone classic slave to master
	typedef struct packed
	{
		logic ack;
		logic [`XLEN-1:0] dat;   // read data, meaningful with ack
	} wbRsp;

endpackage

`default_nettype wire

// ==== design/pcGen.sv ====
`default_nettype none

`include "fetch_macros.svh"

module pcGen (
	input logic clk,
	input logic nrst,
	input fetchPkg::fetchCtrl ctrl,
	input logic [`XLEN-1:0] memInstr,
	output logic memRdEn,
	output logic [`IMEM_AW-1:0] memRdIdx,
	output fetchPkg::fetchPacket fetchOut
);

	logic [`XLEN-1:0] pcFetch;  // stage 1, address being read
	logic [`XLEN-1:0] pcOut;    // stage 2, pc of the word at the memory output
	logic outValid;

	logic [`XLEN-1:0] npc;      // next first-stage pc
	logic [`XLEN-1:0] pcBack;   // one word behind the output
	logic [`XLEN-1:0] rdAddr;
	logic doReplay;

	// replay only makes sense once a word has been delivered
	assign doReplay = ctrl.replay && outValid;
	assign pcBack = pcOut - `XLEN'd4;

	// next pc for the normal advance
	always_comb
	begin
		unique case (ctrl.pcSel)
			fetchPkg::pcSeq:
				npc = pcFetch + `XLEN'd4;
			fetchPkg::pcZero:
				npc = '0;
			fetchPkg::pcTarget:
				npc = ctrl.target;
			fetchPkg::pcHold:
				npc = pcFetch;
			default:
				npc = pcFetch + `XLEN'd4;
		endcase
	end

	// both pc stages and the valid flag
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			pcFetch <= `RESET_PC;
			pcOut <= '0;
			outValid <= 1'b0;
		end
		else if (doReplay)
		begin
			// output steps back, fetch resumes at the old output pc
			pcOut <= pcBack;
			pcFetch <= pcOut;
		end
		else if (!ctrl.stall)
		begin
			pcOut <= pcFetch;
			pcFetch <= npc;
			outValid <= 1'b1;
		end
		// stall holds everything
	end

	// read request to instrMem
	// on replay the word at pcBack is re-read so instr follows pcOut
	assign rdAddr = doReplay ? pcBack : pcFetch;
	assign memRdIdx = rdAddr[`IMEM_AW+1:2]; // word index, upper bits wrap
	assign memRdEn = doReplay || !ctrl.stall;

	// memory output register lines up with pcOut
	always_comb
	begin
		fetchOut.valid = outValid;
		fetchOut.pc = pcOut;
		fetchOut.instr = memInstr;
	end

endmodule

`default_nettype wire

// ==== design/instrMem.sv ====
`default_nettype none

`include "fetch_macros.svh"

module instrMem (
	input logic clk,
	input logic fetchEn,
	input logic [`IMEM_AW-1:0] fetchIdx,
	output logic [`XLEN-1:0] fetchData,
	input logic busEn,
	input logic busWe,
	input logic [3:0] busSel,
	input logic [`IMEM_AW-1:0] busIdx,
	input logic [`XLEN-1:0] busWdata,
	output logic [`XLEN-1:0] busRdata
);

	localparam int depth = 1 << `IMEM_AW;

	logic [`XLEN-1:0] mem [depth];

	// fetch port, read only
	// a same-edge bus write is not visible here (read-first)
	always_ff @(posedge clk)
	begin
		if (fetchEn)
		begin
			fetchData <= mem[fetchIdx];
		end
	end

	// bus port
	// writes honour the byte lanes, reads return the whole word
	always_ff @(posedge clk)
	begin
		if (busEn)
		begin
			if (busWe)
			begin
				for (int b = 0; b < 4; b++)
				begin
					if (busSel[b])
					begin
						mem[busIdx][8*b +: 8] <= busWdata[8*b +: 8];
					end
				end
			end
			else
			begin
				busRdata <= mem[busIdx]; // output held across writes
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/progLoader.sv ====
`default_nettype none

`include "fetch_macros.svh"

module progLoader (
	input logic clk,
	input logic nrst,
	input busPkg::wbReq wbIn,
	output busPkg::wbRsp wbOut,
	output logic memEn,
	output logic memWe,
	output logic [3:0] memSel,
	output logic [`IMEM_AW-1:0] memIdx,
	output logic [`XLEN-1:0] memWdata,
	input logic [`XLEN-1:0] memRdata
);

	logic ackQ;     // ack for the access seen last cycle
	logic ackRead;  // that access was a read
	logic access;   // new access this cycle

	// a held request is not served again while its ack is out,
	// so a master that keeps stb high gets one ack every second cycle
	assign access = wbIn.cyc && wbIn.stb && !ackQ;

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			ackQ <= 1'b0;
			ackRead <= 1'b0;
		end
		else
		begin
			ackQ <= access;
			ackRead <= access && !wbIn.we;
		end
	end

	// memory access goes out in the cycle the request is seen
	// write lands on the same edge that raises ack
	always_comb
	begin
		memEn = access;
		memWe = wbIn.we;
		memSel = wbIn.sel;
		memIdx = wbIn.adr[`IMEM_AW+1:2]; // byte address to word index
		memWdata = wbIn.dat;
	end

	// read data comes straight from the memory output register
	always_comb
	begin
		wbOut.ack = ackQ;
		if (ackRead)
		begin
			wbOut.dat = memRdata;
		end
		else
		begin
			wbOut.dat = '0; // quiet outside read acks
		end
	end

endmodule

`default_nettype wire

// ==== design/fetchTop.sv ====
`default_nettype none

`include "fetch_macros.svh"

module fetchTop (
	input logic clk,
	input logic nrst,
	input fetchPkg::fetchCtrl ctrl,
	output fetchPkg::fetchPacket fetchOut,
	input busPkg::wbReq wbIn,
	output busPkg::wbRsp wbOut
);

	// fetch port
	logic fetchEn;
	logic [`IMEM_AW-1:0] fetchIdx;
	logic [`XLEN-1:0] fetchData;

	// bus port of the memory
	logic busEn;
	logic busWe;
	logic [3:0] busSel;
	logic [`IMEM_AW-1:0] busIdx;
	logic [`XLEN-1:0] busWdata;
	logic [`XLEN-1:0] busRdata;

	pcGen pcGen0 (
		.clk(clk),
		.nrst(nrst),
		.ctrl(ctrl),
		.memInstr(fetchData),
		.memRdEn(fetchEn),
		.memRdIdx(fetchIdx),
		.fetchOut(fetchOut)
	);

	instrMem instrMem0 (
		.clk(clk),
		.fetchEn(fetchEn),
		.fetchIdx(fetchIdx),
		.fetchData(fetchData),
		.busEn(busEn),
		.busWe(busWe),
		.busSel(busSel),
		.busIdx(busIdx),
		.busWdata(busWdata),
		.busRdata(busRdata)
	);

	// program load and readback path
	progLoader progLoader0 (
		.clk(clk),
		.nrst(nrst),
		.wbIn(wbIn),
		.wbOut(wbOut),
		.memEn(busEn),
		.memWe(busWe),
		.memSel(busSel),
		.memIdx(busIdx),
		.memWdata(busWdata),
		.memRdata(busRdata)
	);

endmodule

`default_nettype wire

// ==== sim/fetchTop_assert.sv ====
`default_nettype none

module fetchTopAssert (
	input logic clk,
	input logic nrst,
	input fetchPkg::fetchCtrl ctrl,
	input fetchPkg::fetchPacket fetchOut,
	input busPkg::wbReq wbIn,
	input busPkg::wbRsp wbOut
);

	int failCount = 0; // failed properties so far

	// ack answers a request seen on the edge before
	ackAfterReq: assert property (@(posedge clk) disable iff (!nrst)
		wbOut.ack |-> $past(wbIn.cyc && wbIn.stb))
		else
		begin
			failCount++;
			$error("ack without a request in the cycle before");
		end

	ackSingle: assert property (@(posedge clk) disable iff (!nrst)
		wbOut.ack |=> !wbOut.ack)
		else
		begin
			failCount++;
			$error("ack high in two cycles in a row");
		end

	// a stall freezes the delivered word
	stallHolds: assert property (@(posedge clk) disable iff (!nrst)
		(ctrl.stall && !ctrl.replay && fetchOut.valid) |=> $stable(fetchOut))
		else
		begin
			failCount++;
			$error("fetch output moved during a stall");
		end

	resetQuiet: assert property (@(posedge clk)
		$rose(nrst) |-> !fetchOut.valid)
		else
		begin
			failCount++;
			$error("fetch output valid right after reset");
		end

endmodule

`default_nettype wire

// ==== sim/fetchTb.sv ====
`default_nettype none

`include "fetch_macros.svh"

module fetchTb;

	localparam int words = 1 << `IMEM_AW;
	localparam int phaseLen = 400;
	localparam int clkPeriod = 20;
	// reset, fill and load at 3 cycles per access, free cycle, four fetch phases
	localparam int plannedCycles = 6 + words * 3 + words * 6 + 1 + 4 * phaseLen;

	logic clk;
	logic nrst;
	fetchPkg::fetchCtrl ctrl;
	fetchPkg::fetchPacket fetchOut;
	busPkg::wbReq wbIn;
	busPkg::wbRsp wbOut;
	integer seed;

	// reference model state
	logic [`XLEN-1:0] mirror [0:words-1];
	logic [`XLEN-1:0] mPcFetch;
	fetchPkg::fetchPacket mOut;
	logic mAck;  // ack the slave shows after the coming edge

	fetchTop dut0 (
		.clk(clk),
		.nrst(nrst),
		.ctrl(ctrl),
		.fetchOut(fetchOut),
		.wbIn(wbIn),
		.wbOut(wbOut)
	);

	bind fetchTop fetchTopAssert assert0 (
		.clk(clk),
		.nrst(nrst),
		.ctrl(ctrl),
		.fetchOut(fetchOut),
		.wbIn(wbIn),
		.wbOut(wbOut)
	);

	initial
	begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	// watchdog
	initial
	begin
		#((plannedCycles + 100) * clkPeriod);
		stopOnError("timeout, the run did not finish within the planned cycles");
	end

	always @(dut0.assert0.failCount)
	begin
		if (dut0.assert0.failCount != 0)
			stopOnError("an assertion on the bus or fetch outputs failed");
	end

	function automatic int rndBelow(input int n);
		rndBelow = {$random(seed)} % n;
	endfunction

	// odd multiplier keeps every address bit in the word
	function automatic logic [`XLEN-1:0] fillWord(input int unsigned idx);
		return (idx * 32'h9e37_79b1) ^ 32'h1357_9bdf;
	endfunction

	task automatic stopOnError(input string msg);
		$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic writeMirror(input logic [`XLEN-1:0] adr, input logic [`XLEN-1:0] dat,
			input logic [3:0] sel);
		for (int b = 0; b < 4; b++)
			if (sel[b])
				mirror[adr[`IMEM_AW+1:2]][8*b +: 8] = dat[8*b +: 8];
	endtask

	task automatic checkFetch(input string name, input fetchPkg::fetchPacket exp,
			input fetchPkg::fetchPacket act);
		if (act.valid !== exp.valid || (exp.valid && (act.pc !== exp.pc
				|| act.instr !== exp.instr)))
			stopOnError($sformatf(
				"mismatch %s expected valid=%b pc=%h instr=%h actual valid=%b pc=%h instr=%h",
				name, exp.valid, exp.pc, exp.instr, act.valid, act.pc, act.instr));
	endtask

	task automatic checkBus(input string name, input busPkg::wbRsp exp,
			input busPkg::wbRsp act, input logic withData);
		if (act.ack !== exp.ack || (withData && act.dat !== exp.dat))
			stopOnError($sformatf("mismatch %s expected ack=%b dat=%h actual ack=%b dat=%h",
				name, exp.ack, exp.dat, act.ack, act.dat));
	endtask

	// one classic cycle, held until ack
	task automatic busAccess(input string name, input logic we, input logic [`XLEN-1:0] adr,
			input logic [`XLEN-1:0] dat, input logic [3:0] sel);
		busPkg::wbRsp exp;
		int waited;
		@(negedge clk);
		wbIn.cyc = 1'b1;
		wbIn.stb = 1'b1;
		wbIn.we = we;
		wbIn.adr = adr;
		wbIn.dat = dat;
		wbIn.sel = sel;
		waited = 0;
		do
		begin
			@(negedge clk);
			waited++;
			if (waited > 4)
				stopOnError($sformatf("%s: no ack from the bus slave", name));
		end
		while (wbOut.ack !== 1'b1);
		exp.ack = 1'b1;
		exp.dat = mirror[adr[`IMEM_AW+1:2]];
		checkBus(name, exp, wbOut, !we);
		if (we)
			writeMirror(adr, dat, sel);
		wbIn = '0;
	endtask

	// what the coming rising edge does to the model
	task automatic modelEdge(input fetchPkg::fetchCtrl c, input busPkg::wbReq req);
		logic [`XLEN-1:0] back;
		logic access;
		access = req.cyc && req.stb && !mAck;
		if (c.replay && mOut.valid)
		begin
			back = mOut.pc - 32'd4;
			mPcFetch = mOut.pc;
			mOut.pc = back;
			mOut.instr = mirror[back[`IMEM_AW+1:2]];
		end
		else if (!c.stall)
		begin
			mOut.valid = 1'b1;
			mOut.pc = mPcFetch;
			mOut.instr = mirror[mPcFetch[`IMEM_AW+1:2]];
			case (c.pcSel)
				fetchPkg::pcZero: mPcFetch = '0;
				fetchPkg::pcTarget: mPcFetch = c.target;
				fetchPkg::pcHold: mPcFetch = mPcFetch;
				default: mPcFetch = mPcFetch + 32'd4;
			endcase
		end
		if (access && req.we)
			writeMirror(req.adr, req.dat, req.sel); // after the read, read-first
		mAck = access;
	endtask

	task automatic stepCycle(input string name, input fetchPkg::fetchCtrl c,
			input busPkg::wbReq req);
		busPkg::wbRsp exp;
		ctrl = c;
		wbIn = req;
		modelEdge(c, req);
		@(negedge clk);
		checkFetch(name, mOut, fetchOut);
		exp.ack = mAck;
		exp.dat = '0;
		checkBus(name, exp, wbOut, 1'b0);
	endtask

	task automatic runPhase(input string name, input int redirPct, input int stallPct,
			input int replayPct, input int busPct);
		fetchPkg::fetchCtrl c;
		busPkg::wbReq req;
		int pick;
		for (int n = 0; n < phaseLen; n++)
		begin
			c = '0;
			req = '0;
			c.stall = rndBelow(100) < stallPct;
			c.replay = rndBelow(100) < replayPct;
			c.pcSel = fetchPkg::pcSeq;
			c.target = $random(seed) & ~32'h3;
			if (rndBelow(100) < redirPct)
			begin
				pick = rndBelow(3);
				case (pick)
					0: c.pcSel = fetchPkg::pcZero;
					1: c.pcSel = fetchPkg::pcTarget;
					default: c.pcSel = fetchPkg::pcHold;
				endcase
			end
			if (!mAck && rndBelow(100) < busPct)
			begin
				req.cyc = 1'b1;
				req.stb = 1'b1;
				req.we = 1'b1;
				req.adr = mPcFetch + 4 * rndBelow(5) - 8; // within two words of the fetch pc
				req.dat = $random(seed);
				req.sel = $random(seed);
			end
			stepCycle(name, c, req);
		end
	endtask

	initial
	begin
		fetchPkg::fetchCtrl c;
		busPkg::wbReq req;
		logic [`XLEN-1:0] adr;
		seed = 32'ha0e8_7b76;
		nrst = 1'b0;
		ctrl = '0;
		ctrl.stall = 1'b1; // fetch stays frozen while the program loads
		ctrl.pcSel = fetchPkg::pcSeq;
		wbIn = '0;
		mPcFetch = `RESET_PC;
		mOut = '0;
		mAck = 1'b0;
		repeat (5) @(negedge clk);
		nrst = 1'b1;
		@(negedge clk);
		checkFetch("resetState", mOut, fetchOut);

		for (int i = 0; i < words; i++)
			busAccess("busFill", 1'b1, i * 4, fillWord(i), 4'hf);
		for (int i = 0; i < words; i++)
		begin
			adr = $random(seed); // upper bits and byte offset are don't care
			busAccess("busLoad", 1'b1, adr, $random(seed), $random(seed));
			busAccess("busReadback", 1'b0, adr, '0, 4'h0);
		end
		mAck = 1'b1; // last read ack is still out

		c = '0;
		c.pcSel = fetchPkg::pcSeq;
		req = '0;
		stepCycle("resetFree", c, req);
		runPhase("seqFetch", 0, 0, 0, 0);
		runPhase("redirect", 30, 0, 0, 0);
		runPhase("stallReplay", 15, 25, 10, 0);
		runPhase("busDuringFetch", 10, 15, 5, 40);
		$display("NO ERRORS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== fetchTop.f ====
+incdir+design
design/fetchPkg.sv
design/busPkg.sv
design/pcGen.sv
design/instrMem.sv
design/progLoader.sv
design/fetchTop.sv
sim/fetchTop_assert.sv
sim/fetchTb.sv

// ==== Bender.yml ====
package:
  name: fetch_front

sources:
  - include_dirs:
      - design
    files:
      - design/fetchPkg.sv
      - design/busPkg.sv
      - design/pcGen.sv
      - design/instrMem.sv
      - design/progLoader.sv
      - design/fetchTop.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/fetchTop_assert.sv
      - sim/fetchTb.sv
